// ==== include/preg_defs.svh ====
//==============================
// Sizes for one physical register status entry
// Four dispatch and four retire slots are assumed by the RTL
// Register numbers above PREG_COUNT-1 decode to an empty one-hot
//==============================
`ifndef PREG_DEFS_SVH
`define PREG_DEFS_SVH

// Dispatch and retire slot counts
`define PREG_DISPATCH_SLOTS 4
`define PREG_RETIRE_SLOTS   4

// Physical register file
`define PREG_IID_W          7
`define PREG_NUM_W          7
`define PREG_COUNT          96

// Architectural register file
`define AREG_NUM_W          5
`define AREG_COUNT          32

`endif

// ==== source/preg_pkg.sv ====
//==============================
// Shared types for the register status entry
// Lifecycle state is one-hot, bit 0 is DEALLOC
//==============================
`default_nettype none

`include "preg_defs.svh"

package preg_pkg;

  // Field widths
  typedef logic [`PREG_IID_W-1:0]          iid_t;
  typedef logic [`PREG_NUM_W-1:0]          preg_num_t;
  typedef logic [`AREG_NUM_W-1:0]          areg_num_t;

  // One-hot register vectors
  typedef logic [`PREG_COUNT-1:0]          preg_onehot_t;
  typedef logic [`AREG_COUNT-1:0]          areg_onehot_t;

  // Slot vectors
  typedef logic [`PREG_DISPATCH_SLOTS-1:0] dispatch_vec_t;
  typedef logic [`PREG_RETIRE_SLOTS-1:0]   retire_vec_t;

  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } lifecycle_state_e;

  typedef enum logic {IDLE = 1'b0, WB = 1'b1} wb_state_e;

endpackage

`default_nettype wire

// ==== source/preg_create_select.sv ====
//==============================
// Dispatch slot select for allocation
// At most one slot may be set, otherwise fields are X
//==============================
`timescale 1ns/10ps
`default_nettype none

`include "preg_defs.svh"

module preg_create_select (
  input  preg_pkg::dispatch_vec_t create_vld_slots,
  input  preg_pkg::iid_t          dis_iid      [`PREG_DISPATCH_SLOTS],
  input  preg_pkg::areg_num_t     dis_dst_reg  [`PREG_DISPATCH_SLOTS],
  input  preg_pkg::preg_num_t     dis_rel_preg [`PREG_DISPATCH_SLOTS],
  output logic                    create_vld,
  output preg_pkg::iid_t          create_iid,
  output preg_pkg::areg_num_t     create_dst_reg,
  output preg_pkg::preg_num_t     create_rel_preg
);

  // Any slot allocating this entry
  assign create_vld = |create_vld_slots;

  // Field mux on the one-hot slot vector
  always_comb begin
    case (create_vld_slots)
      4'b0001: begin
        create_iid      = dis_iid[0];
        create_dst_reg  = dis_dst_reg[0];
        create_rel_preg = dis_rel_preg[0];
      end
      4'b0010: begin
        create_iid      = dis_iid[1];
        create_dst_reg  = dis_dst_reg[1];
        create_rel_preg = dis_rel_preg[1];
      end
      4'b0100: begin
        create_iid      = dis_iid[2];
        create_dst_reg  = dis_dst_reg[2];
        create_rel_preg = dis_rel_preg[2];
      end
      4'b1000: begin
        create_iid      = dis_iid[3];
        create_dst_reg  = dis_dst_reg[3];
        create_rel_preg = dis_rel_preg[3];
      end
      default: begin
        // No slot or several slots, value unused
        create_iid      = 'x;
        create_dst_reg  = 'x;
        create_rel_preg = 'x;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/preg_lifecycle.sv ====
//==============================
// Lifecycle and write-back FSMs of one entry
// Flush only acts in WF_ALLOC and ALLOC
// Inputs are single-cycle pulses, no back-pressure
//==============================
`timescale 1ns/10ps
`default_nettype none

module preg_lifecycle (
  input  logic                        sm_clk,
  input  logic                        cpurst_b,
  input  logic                        flush,
  input  logic                        dealloc_vld,
  input  logic                        release_vld,
  input  logic                        wb_vld,
  input  logic                        retire_vld,
  input  logic                        create_vld,
  input  preg_pkg::iid_t              create_iid,
  input  preg_pkg::areg_num_t         create_dst_reg,
  input  preg_pkg::preg_num_t         create_rel_preg,
  output preg_pkg::lifecycle_state_e  state,
  output logic                        wb_done,
  output preg_pkg::iid_t              iid,
  output preg_pkg::areg_num_t         dst_reg,
  output preg_pkg::preg_num_t         rel_preg
);

  preg_pkg::lifecycle_state_e state_nxt;
  preg_pkg::wb_state_e        wb_state;
  preg_pkg::wb_state_e        wb_state_nxt;
  logic                       state_dealloc;

  //==============================
  // Lifecycle FSM
  //==============================
  // DEALLOC  free and written back
  // WF_ALLOC reserved, waiting for a producer
  // ALLOC    owned by a producer
  // RETIRE   producer retired, not yet released
  // RELEASE  released, waiting for write-back

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= preg_pkg::DEALLOC;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      preg_pkg::DEALLOC: begin
        if (dealloc_vld && !flush) begin
          state_nxt = preg_pkg::WF_ALLOC;
        end
      end
      preg_pkg::WF_ALLOC: begin
        if (flush) begin
          state_nxt = preg_pkg::DEALLOC;
        end else if (create_vld) begin
          state_nxt = preg_pkg::ALLOC;
        end
      end
      preg_pkg::ALLOC: begin
        if (flush) begin
          state_nxt = preg_pkg::DEALLOC;
        end else if (release_vld && wb_done) begin
          state_nxt = preg_pkg::DEALLOC;
        end else if (release_vld) begin
          state_nxt = preg_pkg::RELEASE;
        end else if (retire_vld) begin
          state_nxt = preg_pkg::RETIRE;
        end
      end
      preg_pkg::RETIRE: begin
        if (release_vld && wb_done) begin
          state_nxt = preg_pkg::DEALLOC;
        end else if (release_vld) begin
          state_nxt = preg_pkg::RELEASE;
        end
      end
      preg_pkg::RELEASE: begin
        // Free again once the value has landed
        if (wb_done) begin
          state_nxt = preg_pkg::DEALLOC;
        end
      end
      default: begin
        state_nxt = preg_pkg::DEALLOC;
      end
    endcase
  end

  assign state_dealloc = (state == preg_pkg::DEALLOC);

  //==============================
  // Write-back FSM
  //==============================
  // IDLE not written back, WB written back

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_state <= preg_pkg::IDLE;
    end else if (create_vld) begin
      // New producer, old value no longer counts
      wb_state <= preg_pkg::IDLE;
    end else begin
      wb_state <= wb_state_nxt;
    end
  end

  always_comb begin
    wb_state_nxt = wb_state;
    case (wb_state)
      preg_pkg::IDLE: begin
        if (wb_vld) begin
          wb_state_nxt = preg_pkg::WB;
        end
      end
      preg_pkg::WB: begin
        if (state_dealloc) begin
          wb_state_nxt = preg_pkg::IDLE;
        end
      end
      default: begin
        wb_state_nxt = preg_pkg::IDLE;
      end
    endcase
  end

  assign wb_done = (wb_state == preg_pkg::WB);

  //==============================
  // Information register
  //==============================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      iid      <= '0;
      dst_reg  <= '0;
      rel_preg <= '0;
    end else if (create_vld) begin
      iid      <= create_iid;
      dst_reg  <= create_dst_reg;
      rel_preg <= create_rel_preg;
    end
  end

endmodule

`default_nettype wire

// ==== source/preg_retire_release.sv ====
//==============================
// Retire match and release outputs
// Match bits are compared one cycle before the retire pulse
// Release and recovery vectors are combinational
//==============================
`timescale 1ns/10ps
`default_nettype none

`include "preg_defs.svh"

module preg_retire_release (
  input  logic                        sm_clk,
  input  logic                        cpurst_b,
  input  preg_pkg::lifecycle_state_e  state,
  input  logic                        wb_done,
  input  preg_pkg::iid_t              iid,
  input  preg_pkg::areg_num_t         dst_reg,
  input  preg_pkg::preg_num_t         rel_preg,
  input  preg_pkg::retire_vec_t       retire_updt_vld,
  input  preg_pkg::iid_t              retire_updt_iid [`PREG_RETIRE_SLOTS],
  input  preg_pkg::retire_vec_t       retire_preg_vld,
  output logic                        retire_vld,
  output preg_pkg::preg_onehot_t      rel_preg_expand,
  output preg_pkg::areg_onehot_t      dreg,
  output logic                        retired_released_wb
);

  preg_pkg::retire_vec_t  match_updt;
  preg_pkg::retire_vec_t  iid_match;
  preg_pkg::preg_onehot_t rel_preg_dec;
  preg_pkg::areg_onehot_t dst_reg_dec;
  logic                   state_alloc;
  logic                   state_retire;
  logic                   state_release;
  logic                   rel_retire_vld;

  assign state_alloc   = (state == preg_pkg::ALLOC);
  assign state_retire  = (state == preg_pkg::RETIRE);
  assign state_release = (state == preg_pkg::RELEASE);

  //==============================
  // Retire id match
  //==============================
  // Early compare, already qualified by ALLOC
  always_comb begin
    for (int k = 0; k < `PREG_RETIRE_SLOTS; k++) begin
      match_updt[k] = state_alloc && (iid == retire_updt_iid[k]);
    end
  end

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      iid_match <= '0;
    end else begin
      for (int k = 0; k < `PREG_RETIRE_SLOTS; k++) begin
        if (retire_updt_vld[k]) begin
          iid_match[k] <= match_updt[k];
        end
      end
    end
  end

  // Retire seen on any slot with a stored match
  assign retire_vld = |(retire_preg_vld & iid_match);

  //==============================
  // Release vector
  //==============================
  assign rel_preg_dec    = preg_pkg::preg_onehot_t'(1'b1) << rel_preg;
  assign rel_retire_vld  = state_alloc && retire_vld;
  assign rel_preg_expand = {`PREG_COUNT{rel_retire_vld}} & rel_preg_dec;

  //==============================
  // Rename recovery vector
  //==============================
  assign dst_reg_dec = preg_pkg::areg_onehot_t'(1'b1) << dst_reg;
  assign dreg        = {`AREG_COUNT{state_retire}} & dst_reg_dec;

  // Retiring or retired entries report write-back, others read as done
  assign retired_released_wb = (rel_retire_vld || state_retire || state_release)
                               ? wb_done : 1'b1;

endmodule

`default_nettype wire

// ==== source/preg_entry.sv ====
//==============================
// Physical register status entry
// Runs on sm_clk, no clock gating
// create_vld_slots must be at most one-hot
//==============================
`timescale 1ns/10ps
`default_nettype none

`include "preg_defs.svh"

module preg_entry (
  input  logic                    sm_clk,
  input  logic                    cpurst_b,
  input  preg_pkg::dispatch_vec_t create_vld_slots,
  input  preg_pkg::iid_t          dis_iid         [`PREG_DISPATCH_SLOTS],
  input  preg_pkg::areg_num_t     dis_dst_reg     [`PREG_DISPATCH_SLOTS],
  input  preg_pkg::preg_num_t     dis_rel_preg    [`PREG_DISPATCH_SLOTS],
  input  logic                    dealloc_vld,
  input  logic                    release_vld,
  input  logic                    wb_vld,
  input  logic                    flush,
  input  preg_pkg::retire_vec_t   retire_updt_vld,
  input  preg_pkg::iid_t          retire_updt_iid [`PREG_RETIRE_SLOTS],
  input  preg_pkg::retire_vec_t   retire_preg_vld,
  output logic                    cur_state_dealloc,
  output preg_pkg::preg_onehot_t  rel_preg_expand,
  output preg_pkg::areg_onehot_t  dreg,
  output logic                    retired_released_wb
);

  logic                       create_vld;
  preg_pkg::iid_t             create_iid;
  preg_pkg::areg_num_t        create_dst_reg;
  preg_pkg::preg_num_t        create_rel_preg;
  preg_pkg::lifecycle_state_e state;
  logic                       wb_done;
  preg_pkg::iid_t             iid;
  preg_pkg::areg_num_t        dst_reg;
  preg_pkg::preg_num_t        rel_preg;
  logic                       retire_vld;

  preg_create_select u_create_select (
    .create_vld_slots (create_vld_slots),
    .dis_iid          (dis_iid),
    .dis_dst_reg      (dis_dst_reg),
    .dis_rel_preg     (dis_rel_preg),
    .create_vld       (create_vld),
    .create_iid       (create_iid),
    .create_dst_reg   (create_dst_reg),
    .create_rel_preg  (create_rel_preg)
  );

  preg_lifecycle u_lifecycle (
    .sm_clk          (sm_clk),
    .cpurst_b        (cpurst_b),
    .flush           (flush),
    .dealloc_vld     (dealloc_vld),
    .release_vld     (release_vld),
    .wb_vld          (wb_vld),
    .retire_vld      (retire_vld),
    .create_vld      (create_vld),
    .create_iid      (create_iid),
    .create_dst_reg  (create_dst_reg),
    .create_rel_preg (create_rel_preg),
    .state           (state),
    .wb_done         (wb_done),
    .iid             (iid),
    .dst_reg         (dst_reg),
    .rel_preg        (rel_preg)
  );

  preg_retire_release u_retire_release (
    .sm_clk              (sm_clk),
    .cpurst_b            (cpurst_b),
    .state               (state),
    .wb_done             (wb_done),
    .iid                 (iid),
    .dst_reg             (dst_reg),
    .rel_preg            (rel_preg),
    .retire_updt_vld     (retire_updt_vld),
    .retire_updt_iid     (retire_updt_iid),
    .retire_preg_vld     (retire_preg_vld),
    .retire_vld          (retire_vld),
    .rel_preg_expand     (rel_preg_expand),
    .dreg                (dreg),
    .retired_released_wb (retired_released_wb)
  );

  // Bit 0 of the one-hot state is DEALLOC
  assign cur_state_dealloc = state[0];

endmodule

`default_nettype wire

// ==== bench/preg_entry_assert.sv ====
//==============================
// Bound checks on the entry top level
// Only active while reset is released
//==============================
`timescale 1ns/10ps
`default_nettype none

`include "preg_defs.svh"

module preg_entry_assert (
  input wire logic                    sm_clk,
  input wire logic                    cpurst_b,
  input wire preg_pkg::dispatch_vec_t create_vld_slots,
  input wire preg_pkg::preg_onehot_t  rel_preg_expand,
  input wire preg_pkg::areg_onehot_t  dreg,
  input wire logic                    cur_state_dealloc
);

  // Number of assertion failures so far
  int fail_count = 0;

  // At most one dispatch slot allocates
  a_create_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(create_vld_slots))
    else begin
      $error("create_vld_slots has more than one bit set");
      fail_count++;
    end

  // Release and recovery never overlap
  a_rel_dreg_excl: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    !((|rel_preg_expand) && (|dreg)))
    else begin
      $error("rel_preg_expand and dreg both nonzero");
      fail_count++;
    end

  // Free entry shows no recovery
  a_dealloc_no_dreg: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    cur_state_dealloc |-> (dreg == '0))
    else begin
      $error("dreg nonzero while entry is free");
      fail_count++;
    end

endmodule

bind preg_entry preg_entry_assert u_assert (
  .sm_clk            (sm_clk),
  .cpurst_b          (cpurst_b),
  .create_vld_slots  (create_vld_slots),
  .rel_preg_expand   (rel_preg_expand),
  .dreg              (dreg),
  .cur_state_dealloc (cur_state_dealloc)
);

`default_nettype wire

// ==== bench/preg_entry_tb.sv ====
//==============================
// Testbench for the register status entry
// Outputs checked mid low phase against a model
// Model state advances on each rising edge
//==============================
`timescale 1ns/10ps
`default_nettype none

`include "preg_defs.svh"

module preg_entry_tb;

  localparam int PLANNED_CYCLES = 520;

  logic                       sm_clk;
  logic                       cpurst_b;
  preg_pkg::dispatch_vec_t    create_vld_slots;
  preg_pkg::iid_t             dis_iid         [`PREG_DISPATCH_SLOTS];
  preg_pkg::areg_num_t        dis_dst_reg     [`PREG_DISPATCH_SLOTS];
  preg_pkg::preg_num_t        dis_rel_preg    [`PREG_DISPATCH_SLOTS];
  logic                       dealloc_vld;
  logic                       release_vld;
  logic                       wb_vld;
  logic                       flush;
  preg_pkg::retire_vec_t      retire_updt_vld;
  preg_pkg::iid_t             retire_updt_iid [`PREG_RETIRE_SLOTS];
  preg_pkg::retire_vec_t      retire_preg_vld;
  wire                        cur_state_dealloc;
  preg_pkg::preg_onehot_t     rel_preg_expand;
  preg_pkg::areg_onehot_t     dreg;
  wire                        retired_released_wb;

  // Model state
  preg_pkg::lifecycle_state_e m_st;
  logic                       m_wb;
  preg_pkg::iid_t             m_iid;
  preg_pkg::areg_num_t        m_dst;
  preg_pkg::preg_num_t        m_rel;
  preg_pkg::retire_vec_t      m_match;
  integer                     seed;

  preg_entry uut (.*);

  always #4 sm_clk = ~sm_clk;

  function automatic preg_pkg::preg_onehot_t preg_bit(preg_pkg::preg_num_t n);
    preg_pkg::preg_onehot_t v;
    v = '0;
    if (n < `PREG_COUNT) v[n] = 1'b1;
    return v;
  endfunction

  function automatic preg_pkg::areg_onehot_t areg_bit(preg_pkg::areg_num_t n);
    preg_pkg::areg_onehot_t v;
    v = '0;
    v[n] = 1'b1;
    return v;
  endfunction

  // Expected outputs of this cycle and the model's next state
  function automatic void ref_step(output preg_pkg::lifecycle_state_e n_st,
                                   output logic n_wb, output preg_pkg::retire_vec_t n_match,
                                   output preg_pkg::preg_onehot_t e_rel,
                                   output preg_pkg::areg_onehot_t e_dreg,
                                   output logic e_rrwb, output logic e_dealloc);
    logic retire;
    logic create;
    retire = |(retire_preg_vld & m_match);
    create = |create_vld_slots;
    n_st = m_st;
    case (m_st)
      preg_pkg::DEALLOC:  if (dealloc_vld && !flush) n_st = preg_pkg::WF_ALLOC;
      preg_pkg::WF_ALLOC: if (flush) n_st = preg_pkg::DEALLOC;
                          else if (create) n_st = preg_pkg::ALLOC;
      preg_pkg::ALLOC:    if (flush || (release_vld && m_wb)) n_st = preg_pkg::DEALLOC;
                          else if (release_vld) n_st = preg_pkg::RELEASE;
                          else if (retire) n_st = preg_pkg::RETIRE;
      preg_pkg::RETIRE:   if (release_vld) n_st = m_wb ? preg_pkg::DEALLOC : preg_pkg::RELEASE;
      default:            if (m_wb) n_st = preg_pkg::DEALLOC;
    endcase
    if (create) n_wb = 1'b0;
    else if (!m_wb) n_wb = wb_vld;
    else n_wb = !(m_st == preg_pkg::DEALLOC);
    n_match = m_match;
    for (int k = 0; k < `PREG_RETIRE_SLOTS; k++) begin
      if (retire_updt_vld[k]) begin
        n_match[k] = (m_st == preg_pkg::ALLOC) && (m_iid == retire_updt_iid[k]);
      end
    end
    e_rel = (m_st == preg_pkg::ALLOC && retire) ? preg_bit(m_rel) : '0;
    e_dreg = (m_st == preg_pkg::RETIRE) ? areg_bit(m_dst) : '0;
    e_rrwb = ((m_st == preg_pkg::ALLOC && retire) || m_st == preg_pkg::RETIRE ||
              m_st == preg_pkg::RELEASE) ? m_wb : 1'b1;
    e_dealloc = (m_st == preg_pkg::DEALLOC);
  endfunction

  task automatic stop_on_error(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_preg(string name, preg_pkg::preg_onehot_t act, preg_pkg::preg_onehot_t exp);
    if (act !== exp) stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, act, exp));
  endtask

  task automatic check_areg(string name, preg_pkg::areg_onehot_t act, preg_pkg::areg_onehot_t exp);
    if (act !== exp) stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, act, exp));
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp) stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, act, exp));
  endtask

  // Compare in the middle of the low phase
  always @(negedge sm_clk) begin
    preg_pkg::lifecycle_state_e n_st;
    logic n_wb;
    preg_pkg::retire_vec_t n_match;
    preg_pkg::preg_onehot_t e_rel;
    preg_pkg::areg_onehot_t e_dreg;
    logic e_rrwb;
    logic e_dealloc;
    #2;
    if (cpurst_b) begin
      ref_step(n_st, n_wb, n_match, e_rel, e_dreg, e_rrwb, e_dealloc);
      check_bit("cur_state_dealloc", cur_state_dealloc, e_dealloc);
      check_bit("retired_released_wb", retired_released_wb, e_rrwb);
      check_preg("rel_preg_expand", rel_preg_expand, e_rel);
      check_areg("dreg", dreg, e_dreg);
    end
  end

  always @(posedge sm_clk) begin
    preg_pkg::lifecycle_state_e n_st;
    logic n_wb;
    preg_pkg::retire_vec_t n_match;
    preg_pkg::preg_onehot_t e_rel;
    preg_pkg::areg_onehot_t e_dreg;
    logic e_rrwb;
    logic e_dealloc;
    if (cpurst_b) begin
      ref_step(n_st, n_wb, n_match, e_rel, e_dreg, e_rrwb, e_dealloc);
      for (int k = 0; k < `PREG_DISPATCH_SLOTS; k++) begin
        if (create_vld_slots[k]) begin
          m_iid = dis_iid[k];
          m_dst = dis_dst_reg[k];
          m_rel = dis_rel_preg[k];
        end
      end
      m_st = n_st;
      m_wb = n_wb;
      m_match = n_match;
    end
  end

  // Watchdog
  initial begin
    #(8 * PLANNED_CYCLES * 8);
    $display("watchdog expired before the tests completed");
    $display("tests failed");
    $fatal(1, "timeout");
  end

  task automatic clear_inputs();
    create_vld_slots = '0;
    dealloc_vld = 1'b0;
    release_vld = 1'b0;
    wb_vld = 1'b0;
    flush = 1'b0;
    retire_updt_vld = '0;
    retire_preg_vld = '0;
  endtask

  task automatic start_cycle();
    @(negedge sm_clk);
    clear_inputs();
  endtask

  task automatic alloc_entry(int slot, preg_pkg::iid_t id, preg_pkg::areg_num_t dst,
                             preg_pkg::preg_num_t rel);
    start_cycle();
    dealloc_vld = 1'b1;
    start_cycle();
    create_vld_slots[slot] = 1'b1;
    dis_iid[slot] = id;
    dis_dst_reg[slot] = dst;
    dis_rel_preg[slot] = rel;
  endtask

  task automatic send_update(int slot, preg_pkg::iid_t id);
    start_cycle();
    retire_updt_vld[slot] = 1'b1;
    retire_updt_iid[slot] = id;
  endtask

  task automatic send_retire(int slot);
    start_cycle();
    retire_preg_vld[slot] = 1'b1;
    #2;
  endtask

  task automatic wait_dealloc(int max_cycles);
    bool_loop: for (int i = 0; i < max_cycles; i++) begin
      start_cycle();
      #2;
      if (cur_state_dealloc) return;
    end
    stop_on_error("entry did not return to the free state in time");
  endtask

  task automatic random_cycle();
    int s;
    start_cycle();
    s = $unsigned($random(seed)) % `PREG_DISPATCH_SLOTS;
    dealloc_vld = ($random(seed) % 4) == 0;
    release_vld = ($random(seed) % 8) == 0;
    wb_vld = ($random(seed) % 6) == 0;
    flush = ($random(seed) % 20) == 0;
    if (($random(seed) % 3) == 0) begin
      create_vld_slots[s] = 1'b1;
      dis_iid[s] = $random(seed);
      dis_dst_reg[s] = $random(seed);
      dis_rel_preg[s] = $unsigned($random(seed)) % `PREG_COUNT;
    end
    s = $unsigned($random(seed)) % `PREG_RETIRE_SLOTS;
    retire_updt_vld[s] = ($random(seed) % 3) == 0;
    retire_updt_iid[s] = ($random(seed) % 2) ? m_iid : preg_pkg::iid_t'($random(seed));
    retire_preg_vld = $random(seed);
  endtask

  initial begin
    int s;
    preg_pkg::iid_t id;
    preg_pkg::areg_num_t dst;
    preg_pkg::preg_num_t rel;
    seed = 99816;
    sm_clk = 1'b0;
    cpurst_b = 1'b0;
    clear_inputs();
    for (int k = 0; k < 4; k++) begin
      dis_iid[k] = '0;
      dis_dst_reg[k] = '0;
      dis_rel_preg[k] = '0;
      retire_updt_iid[k] = '0;
    end
    m_st = preg_pkg::DEALLOC;
    m_wb = 1'b0;
    m_iid = '0;
    m_dst = '0;
    m_rel = '0;
    m_match = '0;
    repeat (8) @(negedge sm_clk);
    cpurst_b = 1'b1;
    // Reset values
    start_cycle();
    #2;
    check_bit("cur_state_dealloc", cur_state_dealloc, 1'b1);
    check_bit("retired_released_wb", retired_released_wb, 1'b1);
    check_preg("rel_preg_expand", rel_preg_expand, '0);
    check_areg("dreg", dreg, '0);
    // Full life of one register
    s = $unsigned($random(seed)) % 4;
    id = $random(seed);
    dst = $random(seed);
    rel = $unsigned($random(seed)) % `PREG_COUNT;
    alloc_entry(s, id, dst, rel);
    start_cycle();
    wb_vld = 1'b1;
    send_update(s, id);
    send_retire(s);
    check_preg("rel_preg_expand", rel_preg_expand, preg_bit(rel));
    start_cycle();
    #2;
    check_areg("dreg", dreg, areg_bit(dst));
    start_cycle();
    release_vld = 1'b1;
    wait_dealloc(4);
    // Wrong iid, then a stale update from before the allocation
    alloc_entry(s, id, dst, rel);
    send_update(s, id ^ 7'h01);
    send_retire(s);
    check_preg("rel_preg_expand", rel_preg_expand, '0);
    start_cycle();
    flush = 1'b1;
    wait_dealloc(4);
    send_update((s + 1) % 4, id);
    alloc_entry(s, id, dst, rel);
    send_retire((s + 1) % 4);
    check_preg("rel_preg_expand", rel_preg_expand, '0);
    // Release before write-back
    send_update(s, id);
    send_retire(s);
    start_cycle();
    release_vld = 1'b1;
    repeat (3) begin
      start_cycle();
      #2;
      check_bit("retired_released_wb", retired_released_wb, 1'b0);
    end
    start_cycle();
    wb_vld = 1'b1;
    wait_dealloc(4);
    // Flush while reserved and while allocated
    start_cycle();
    dealloc_vld = 1'b1;
    start_cycle();
    flush = 1'b1;
    wait_dealloc(4);
    alloc_entry(s, id, dst, rel);
    start_cycle();
    flush = 1'b1;
    wait_dealloc(4);
    repeat (400) random_cycle();
    start_cycle();
    start_cycle();
    if (uut.u_assert.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "assertion failures found");
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/preg_pkg.sv
source/preg_create_select.sv
source/preg_lifecycle.sv
source/preg_retire_release.sv
source/preg_entry.sv
bench/preg_entry_assert.sv
bench/preg_entry_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the entry testbench with Verilator
# Exit status is nonzero when the simulation fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wall -Wno-fatal \
  -f tb.f --top-module preg_entry_tb -o preg_entry_sim &&
./obj_dir/preg_entry_sim || exit 1
